//--- common/m_unit_pkg.sv
package m_unit_pkg;

  //////////////////////////////////////////////////////////////////////
  // Sizes fixed by the ISA
  //////////////////////////////////////////////////////////////////////

  // Data word width
  localparam int XLEN = 32;

  // Architectural registers x0..x31
  localparam int NUM_REGS = 32;

  // Register index width
  localparam int REG_ADDR_W = $clog2(NUM_REGS);

  // Major opcode of R-type register instructions
  localparam logic [6:0] OPCODE_OP = 7'h33;

  // funct7 value selecting RV32M
  localparam logic [6:0] FUNCT7_MULDIV = 7'b000_0001;

  //////////////////////////////////////////////////////////////////////
  // Wishbone word map
  //////////////////////////////////////////////////////////////////////

  // Word indices 0..31 hit the register file
  localparam logic [5:0] WB_ADR_INSTR  = 6'd32;
  localparam logic [5:0] WB_ADR_STATUS = 6'd33;

  // M operators, encoding equals funct3
  typedef enum logic [2:0] {
    MD_MUL    = 3'b000,
    MD_MULH   = 3'b001,
    MD_MULHSU = 3'b010,
    MD_MULHU  = 3'b011,
    MD_DIV    = 3'b100,
    MD_DIVU   = 3'b101,
    MD_REM    = 3'b110,
    MD_REMU   = 3'b111
  } md_op_e;

  // R-type field layout
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_type_t;

  // Instruction word, raw or split into fields
  typedef union packed {
    logic [31:0] raw;
    r_type_t     r;
  } instr_u;

  // Decoder outputs
  typedef struct packed {
    logic       illegal_insn;
    logic       rf_we;
    logic [1:0] rf_re;
    logic       mult_en;
    logic       div_en;
    md_op_e     md_operator;
  } decoder_ctrl_t;

  // Illegal, nothing enabled
  localparam decoder_ctrl_t DECODER_CTRL_ILLEGAL_INSN = '{
    illegal_insn: 1'b1,
    rf_we:        1'b0,
    rf_re:        2'b00,
    mult_en:      1'b0,
    div_en:       1'b0,
    md_operator:  MD_MUL
  };

endpackage

//--- common/m_op_if.sv
`timescale 1ns/1ps

// Controller to arithmetic unit link
interface m_op_if;

  // One-cycle start, operands valid with it
  logic start;
  logic [m_unit_pkg::XLEN-1:0] op_a;
  logic [m_unit_pkg::XLEN-1:0] op_b;
  m_unit_pkg::md_op_e operator;

  // One-cycle done, result valid with it
  logic done;
  logic [m_unit_pkg::XLEN-1:0] result;

  // Controller side
  modport ctrl (
    output start,
    output op_a,
    output op_b,
    output operator,
    input  done,
    input  result
  );

  // Arithmetic unit side
  modport unit (
    input  start,
    input  op_a,
    input  op_b,
    input  operator,
    output done,
    output result
  );

endinterface

//--- src/m_decoder.sv
`timescale 1ns/1ps

module m_decoder (
  input  m_unit_pkg::instr_u        instr_i,
  output m_unit_pkg::decoder_ctrl_t decoder_ctrl_o
);

  //////////////////////////////////////////////////////////////////////
  // RV32M decode
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    // Start illegal
    decoder_ctrl_o = m_unit_pkg::DECODER_CTRL_ILLEGAL_INSN;

    // Every M op reads rs1, rs2 and writes rd
    decoder_ctrl_o.rf_we    = 1'b1;
    decoder_ctrl_o.rf_re[0] = 1'b1;
    decoder_ctrl_o.rf_re[1] = 1'b1;

    // Operator is funct3 as is
    decoder_ctrl_o.md_operator = m_unit_pkg::md_op_e'(instr_i.r.funct3);

    unique case (instr_i.r.opcode)
      m_unit_pkg::OPCODE_OP: begin
        if (instr_i.r.funct7 == m_unit_pkg::FUNCT7_MULDIV) begin
          decoder_ctrl_o.illegal_insn = 1'b0;
          unique case (instr_i.r.funct3)
            // mul, mulh, mulhsu, mulhu
            3'b000,
            3'b001,
            3'b010,
            3'b011: begin
              decoder_ctrl_o.mult_en = 1'b1;
            end
            // div, divu, rem, remu
            3'b100,
            3'b101,
            3'b110,
            3'b111: begin
              decoder_ctrl_o.div_en = 1'b1;
            end
          endcase
        end else begin
          // add, sub and friends land here
          decoder_ctrl_o = m_unit_pkg::DECODER_CTRL_ILLEGAL_INSN;
        end
      end

      default: begin
        // Not a register-register op
        decoder_ctrl_o = m_unit_pkg::DECODER_CTRL_ILLEGAL_INSN;
      end
    endcase
  end

endmodule

//--- src/m_regfile.sv
`timescale 1ns/1ps

module m_regfile (
  input  logic                                clk_i,
  input  logic                                arst_n_i,
  input  logic [m_unit_pkg::REG_ADDR_W-1:0]   raddr_a_i,
  input  logic [m_unit_pkg::REG_ADDR_W-1:0]   raddr_b_i,
  output logic [m_unit_pkg::XLEN-1:0]         rdata_a_o,
  output logic [m_unit_pkg::XLEN-1:0]         rdata_b_o,
  input  logic                                we_i,
  input  logic [m_unit_pkg::REG_ADDR_W-1:0]   waddr_i,
  input  logic [m_unit_pkg::XLEN-1:0]         wdata_i
);

  // Register storage
  logic [m_unit_pkg::XLEN-1:0] regs_q [m_unit_pkg::NUM_REGS];

  // Write port, x0 never written so it stays zero
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < m_unit_pkg::NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // Asynchronous reads
  assign rdata_a_o = regs_q[raddr_a_i];
  assign rdata_b_o = regs_q[raddr_b_i];

endmodule

//--- mul_div/m_multiplier.sv
`timescale 1ns/1ps

module m_multiplier (
  input logic  clk_i,
  input logic  arst_n_i,
  m_op_if.unit op_if
);

  // Per-operand signedness
  logic a_signed;
  logic b_signed;

  // Operands widened by one bit, so one signed multiply covers all forms
  logic signed [m_unit_pkg::XLEN:0] op_a_ext;
  logic signed [m_unit_pkg::XLEN:0] op_b_ext;

  // Full product, top two bits unused
  logic signed [2*m_unit_pkg::XLEN+1:0] product;

  // Output stage
  logic [m_unit_pkg::XLEN-1:0] result_q;
  logic                        done_q;

  always_comb begin
    // mulh is s*s, mulhsu is s*u, mul and mulhu are u*u
    a_signed = (op_if.operator == m_unit_pkg::MD_MULH) ||
               (op_if.operator == m_unit_pkg::MD_MULHSU);
    b_signed = (op_if.operator == m_unit_pkg::MD_MULH);
    op_a_ext = {a_signed & op_if.op_a[m_unit_pkg::XLEN-1], op_if.op_a};
    op_b_ext = {b_signed & op_if.op_b[m_unit_pkg::XLEN-1], op_if.op_b};
    product  = op_a_ext * op_b_ext;
  end

  // Low word for mul, high word otherwise
  always_ff @(posedge clk_i) begin
    if (op_if.start) begin
      if (op_if.operator == m_unit_pkg::MD_MUL) begin
        result_q <= product[m_unit_pkg::XLEN-1:0];
      end else begin
        result_q <= product[2*m_unit_pkg::XLEN-1:m_unit_pkg::XLEN];
      end
    end
  end

  // Done one cycle after start
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      done_q <= 1'b0;
    end else begin
      done_q <= op_if.start;
    end
  end

  assign op_if.done   = done_q;
  assign op_if.result = result_q;

endmodule

//--- mul_div/m_divider.sv
`timescale 1ns/1ps

module m_divider (
  input logic  clk_i,
  input logic  arst_n_i,
  m_op_if.unit op_if
);

  // Control
  logic                                  busy_q;
  logic                                  fix_q;
  logic                                  done_q;
  logic [$clog2(m_unit_pkg::XLEN)-1:0]   cnt_q;

  // Operand prep
  logic                        signed_op;
  logic                        a_neg;
  logic                        b_neg;
  logic [m_unit_pkg::XLEN-1:0] abs_a;
  logic [m_unit_pkg::XLEN-1:0] abs_b;

  // Iteration state, quot_q shifts the dividend out as quotient bits come in
  logic [m_unit_pkg::XLEN-1:0] rem_q;
  logic [m_unit_pkg::XLEN-1:0] quot_q;
  logic [m_unit_pkg::XLEN-1:0] divisor_q;
  logic [m_unit_pkg::XLEN-1:0] dividend_q;
  logic                        neg_quot_q;
  logic                        neg_rem_q;
  logic                        div_zero_q;
  logic                        is_rem_q;

  // One step
  logic [m_unit_pkg::XLEN:0]   rem_shift;
  logic [m_unit_pkg::XLEN:0]   diff;
  logic [m_unit_pkg::XLEN-1:0] rem_next;
  logic [m_unit_pkg::XLEN-1:0] quot_next;

  // Sign fix and result
  logic [m_unit_pkg::XLEN-1:0] quot_fix;
  logic [m_unit_pkg::XLEN-1:0] rem_fix;
  logic [m_unit_pkg::XLEN-1:0] final_res;
  logic [m_unit_pkg::XLEN-1:0] result_q;

  //////////////////////////////////////////////////////////////////////
  // Datapath
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    signed_op = (op_if.operator == m_unit_pkg::MD_DIV) ||
                (op_if.operator == m_unit_pkg::MD_REM);
    a_neg = signed_op & op_if.op_a[m_unit_pkg::XLEN-1];
    b_neg = signed_op & op_if.op_b[m_unit_pkg::XLEN-1];
    abs_a = a_neg ? -op_if.op_a : op_if.op_a;
    abs_b = b_neg ? -op_if.op_b : op_if.op_b;

    // Shift next dividend bit in, try to subtract
    rem_shift = {rem_q, quot_q[m_unit_pkg::XLEN-1]};
    diff      = rem_shift - {1'b0, divisor_q};
    if (diff[m_unit_pkg::XLEN]) begin
      // Borrow, keep remainder
      rem_next  = rem_shift[m_unit_pkg::XLEN-1:0];
      quot_next = {quot_q[m_unit_pkg::XLEN-2:0], 1'b0};
    end else begin
      rem_next  = diff[m_unit_pkg::XLEN-1:0];
      quot_next = {quot_q[m_unit_pkg::XLEN-2:0], 1'b1};
    end

    // Quotient sign from both operands, remainder from dividend.
    // MIN / -1 comes out right here: |MIN| is 2^31, negated back to MIN, rem 0.
    quot_fix = neg_quot_q ? -quot_q : quot_q;
    rem_fix  = neg_rem_q ? -rem_q : rem_q;

    // Zero divisor, all-ones quotient and dividend as remainder
    if (div_zero_q) begin
      final_res = is_rem_q ? dividend_q : '1;
    end else begin
      final_res = is_rem_q ? rem_fix : quot_fix;
    end
  end

  always_ff @(posedge clk_i) begin
    if (op_if.start) begin
      dividend_q <= op_if.op_a;
      divisor_q  <= abs_b;
      quot_q     <= abs_a;
      rem_q      <= '0;
      neg_quot_q <= a_neg ^ b_neg;
      neg_rem_q  <= a_neg;
      div_zero_q <= (op_if.op_b == '0);
      is_rem_q   <= (op_if.operator == m_unit_pkg::MD_REM) ||
                    (op_if.operator == m_unit_pkg::MD_REMU);
    end else if (busy_q) begin
      rem_q  <= rem_next;
      quot_q <= quot_next;
    end
    if (fix_q) begin
      result_q <= final_res;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Sequencing, start -> 32 steps -> fix -> done
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q <= 1'b0;
      fix_q  <= 1'b0;
      done_q <= 1'b0;
      cnt_q  <= '0;
    end else begin
      done_q <= fix_q;
      fix_q  <= 1'b0;
      if (op_if.start) begin
        busy_q <= 1'b1;
        cnt_q  <= '0;
      end else if (busy_q) begin
        cnt_q <= cnt_q + 1'b1;
        // Counter full on the last step
        if (&cnt_q) begin
          busy_q <= 1'b0;
          fix_q  <= 1'b1;
        end
      end
    end
  end

  assign op_if.done   = done_q;
  assign op_if.result = result_q;

endmodule

//--- src/m_wb_ctrl.sv
`timescale 1ns/1ps

module m_wb_ctrl (
  input  logic                                clk_i,
  input  logic                                arst_n_i,
  // Wishbone classic slave
  input  logic                                wb_cyc_i,
  input  logic                                wb_stb_i,
  input  logic                                wb_we_i,
  input  logic [7:0]                          wb_adr_i,
  input  logic [m_unit_pkg::XLEN-1:0]         wb_dat_i,
  input  logic [3:0]                          wb_sel_i,
  output logic [m_unit_pkg::XLEN-1:0]         wb_dat_o,
  output logic                                wb_ack_o,
  // Decoder
  output m_unit_pkg::instr_u                  instr_o,
  input  m_unit_pkg::decoder_ctrl_t           decoder_ctrl_i,
  // Register file
  output logic [m_unit_pkg::REG_ADDR_W-1:0]   rf_raddr_a_o,
  output logic [m_unit_pkg::REG_ADDR_W-1:0]   rf_raddr_b_o,
  input  logic [m_unit_pkg::XLEN-1:0]         rf_rdata_a_i,
  input  logic [m_unit_pkg::XLEN-1:0]         rf_rdata_b_i,
  output logic                                rf_we_o,
  output logic [m_unit_pkg::REG_ADDR_W-1:0]   rf_waddr_o,
  output logic [m_unit_pkg::XLEN-1:0]         rf_wdata_o,
  // Arithmetic units
  m_op_if.ctrl                                mul_if,
  m_op_if.ctrl                                div_if
);

  // Address decode
  logic [5:0] adr_word;
  logic       reg_hit;
  logic       instr_wr;
  logic       accept;

  // Sequencer phases, all clear means idle
  logic dec_q;
  logic exec_q;
  logic resp_q;
  logic ack_q;

  // Architectural state
  m_unit_pkg::instr_u          instr_q;
  logic                        illegal_q;
  logic                        rd_we_q;
  logic [m_unit_pkg::XLEN-1:0] result_q;
  logic [m_unit_pkg::XLEN-1:0] rd_data;
  logic [m_unit_pkg::XLEN-1:0] dat_q;
  logic                        unit_done;

  //////////////////////////////////////////////////////////////////////
  // Wishbone decode
  //////////////////////////////////////////////////////////////////////

  // Byte address to word index
  assign adr_word = wb_adr_i[7:2];
  assign reg_hit  = ~adr_word[5];
  assign instr_wr = wb_we_i & (adr_word == m_unit_pkg::WB_ADR_INSTR);

  // New request only when idle and not mid-ack
  assign accept = wb_cyc_i & wb_stb_i & ~ack_q & ~(dec_q | exec_q | resp_q);

  // Read mux, other indices read zero
  always_comb begin
    rd_data = '0;
    if (reg_hit) begin
      rd_data = rf_rdata_a_i;
    end else if (adr_word == m_unit_pkg::WB_ADR_INSTR) begin
      rd_data = instr_q.raw;
    end else if (adr_word == m_unit_pkg::WB_ADR_STATUS) begin
      rd_data = {{(m_unit_pkg::XLEN-1){1'b0}}, illegal_q};
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Issue / execute / writeback
  //////////////////////////////////////////////////////////////////////

  assign unit_done = mul_if.done | div_if.done;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      dec_q     <= 1'b0;
      exec_q    <= 1'b0;
      resp_q    <= 1'b0;
      ack_q     <= 1'b0;
      illegal_q <= 1'b0;
      rd_we_q   <= 1'b0;
      instr_q   <= '0;
    end else begin
      ack_q  <= 1'b0;
      dec_q  <= 1'b0;
      resp_q <= 1'b0;
      if (accept) begin
        if (instr_wr) begin
          // Latch word, ack held back
          instr_q.raw <= wb_dat_i;
          dec_q       <= 1'b1;
        end else begin
          ack_q <= 1'b1;
        end
      end
      if (dec_q) begin
        illegal_q <= decoder_ctrl_i.illegal_insn;
        rd_we_q   <= decoder_ctrl_i.rf_we;
        if (decoder_ctrl_i.illegal_insn) begin
          // Nothing to run, respond without write
          ack_q  <= 1'b1;
          resp_q <= 1'b1;
        end else begin
          exec_q <= 1'b1;
        end
      end
      if (exec_q && unit_done) begin
        exec_q <= 1'b0;
        ack_q  <= 1'b1;
        resp_q <= 1'b1;
      end
    end
  end

  // Read data and unit result
  always_ff @(posedge clk_i) begin
    if (accept) begin
      dat_q <= rd_data;
    end
    if (exec_q && unit_done) begin
      result_q <= mul_if.done ? mul_if.result : div_if.result;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Register file and unit hookup
  //////////////////////////////////////////////////////////////////////

  // Port A shared with host reads, rs1 during decode
  always_comb begin
    if (dec_q) begin
      rf_raddr_a_o = decoder_ctrl_i.rf_re[0] ? instr_q.r.rs1 : '0;
    end else begin
      rf_raddr_a_o = adr_word[m_unit_pkg::REG_ADDR_W-1:0];
    end
    rf_raddr_b_o = decoder_ctrl_i.rf_re[1] ? instr_q.r.rs2 : '0;
  end

  // Writeback in the ack cycle, host writes need all byte lanes
  assign rf_we_o = (resp_q & rd_we_q) |
                   (accept & wb_we_i & reg_hit & (&wb_sel_i));
  assign rf_waddr_o = resp_q ? instr_q.r.rd : adr_word[m_unit_pkg::REG_ADDR_W-1:0];
  assign rf_wdata_o = resp_q ? result_q : wb_dat_i;

  // Start the unit picked by the decoder
  assign mul_if.start    = dec_q & decoder_ctrl_i.mult_en;
  assign mul_if.op_a     = rf_rdata_a_i;
  assign mul_if.op_b     = rf_rdata_b_i;
  assign mul_if.operator = decoder_ctrl_i.md_operator;

  assign div_if.start    = dec_q & decoder_ctrl_i.div_en;
  assign div_if.op_a     = rf_rdata_a_i;
  assign div_if.op_b     = rf_rdata_b_i;
  assign div_if.operator = decoder_ctrl_i.md_operator;

  assign instr_o  = instr_q;
  assign wb_dat_o = dat_q;
  assign wb_ack_o = ack_q;

endmodule

//--- src/m_unit_top.sv
`timescale 1ns/1ps

module m_unit_top (
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  input  logic                        wb_cyc_i,
  input  logic                        wb_stb_i,
  input  logic                        wb_we_i,
  input  logic [7:0]                  wb_adr_i,
  input  logic [m_unit_pkg::XLEN-1:0] wb_dat_i,
  input  logic [3:0]                  wb_sel_i,
  output logic [m_unit_pkg::XLEN-1:0] wb_dat_o,
  output logic                        wb_ack_o
);

  // Controller to decoder
  m_unit_pkg::instr_u        instr;
  m_unit_pkg::decoder_ctrl_t decoder_ctrl;

  // Controller to register file
  logic [m_unit_pkg::REG_ADDR_W-1:0] rf_raddr_a;
  logic [m_unit_pkg::REG_ADDR_W-1:0] rf_raddr_b;
  logic [m_unit_pkg::XLEN-1:0]       rf_rdata_a;
  logic [m_unit_pkg::XLEN-1:0]       rf_rdata_b;
  logic                              rf_we;
  logic [m_unit_pkg::REG_ADDR_W-1:0] rf_waddr;
  logic [m_unit_pkg::XLEN-1:0]       rf_wdata;

  // One link per arithmetic unit
  m_op_if mul_if ();
  m_op_if div_if ();

  m_wb_ctrl m_wb_ctrl_inst (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .wb_cyc_i       (wb_cyc_i),
    .wb_stb_i       (wb_stb_i),
    .wb_we_i        (wb_we_i),
    .wb_adr_i       (wb_adr_i),
    .wb_dat_i       (wb_dat_i),
    .wb_sel_i       (wb_sel_i),
    .wb_dat_o       (wb_dat_o),
    .wb_ack_o       (wb_ack_o),
    .instr_o        (instr),
    .decoder_ctrl_i (decoder_ctrl),
    .rf_raddr_a_o   (rf_raddr_a),
    .rf_raddr_b_o   (rf_raddr_b),
    .rf_rdata_a_i   (rf_rdata_a),
    .rf_rdata_b_i   (rf_rdata_b),
    .rf_we_o        (rf_we),
    .rf_waddr_o     (rf_waddr),
    .rf_wdata_o     (rf_wdata),
    .mul_if         (mul_if),
    .div_if         (div_if)
  );

  m_decoder m_decoder_inst (
    .instr_i        (instr),
    .decoder_ctrl_o (decoder_ctrl)
  );

  m_regfile m_regfile_inst (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .raddr_a_i (rf_raddr_a),
    .raddr_b_i (rf_raddr_b),
    .rdata_a_o (rf_rdata_a),
    .rdata_b_o (rf_rdata_b),
    .we_i      (rf_we),
    .waddr_i   (rf_waddr),
    .wdata_i   (rf_wdata)
  );

  m_multiplier m_multiplier_inst (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .op_if    (mul_if)
  );

  m_divider m_divider_inst (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .op_if    (div_if)
  );

endmodule

//--- testbench/m_unit_tb.sv
`timescale 1ns/1ps

module m_unit_tb;

  // Table size
  localparam int NUM_FIXED = 33;
  localparam int NUM_RAND  = 32;
  localparam int NUM_ROWS  = NUM_FIXED + NUM_RAND;

  // Reset plus register sweep stay under 420 cycles, a divide row under 60
  localparam int MAX_CYCLES = 16 + 400 + NUM_ROWS * 60;

  // One table entry, registers come from the instruction fields
  typedef struct packed {
    logic [31:0] instr;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] expected;
    logic        legal;
  } row_t;

  logic        clk;
  logic        arst_n;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [7:0]  wb_adr;
  logic [31:0] wb_dat;
  logic [3:0]  wb_sel;
  logic [31:0] wb_rdat;
  logic        wb_ack;

  row_t   rows[$];
  integer seed;
  int     cycle_cnt = 0;

  m_unit_top m_unit_top_inst (
    .clk_i    (clk),
    .arst_n_i (arst_n),
    .wb_cyc_i (wb_cyc),
    .wb_stb_i (wb_stb),
    .wb_we_i  (wb_we),
    .wb_adr_i (wb_adr),
    .wb_dat_i (wb_dat),
    .wb_sel_i (wb_sel),
    .wb_dat_o (wb_rdat),
    .wb_ack_o (wb_ack)
  );

  // 10 ns clock
  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // Reporting
  //////////////////////////////////////////////////////////////////////

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Test failed");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic expect_word(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      abort_run($sformatf("CHECK FAILED at %0t ns: %s, read %h, expected %h",
                          $time, what, got, exp));
    end
  endtask

  // Hang guard
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      abort_run($sformatf("Timeout: DUT did not finish within %0d cycles", MAX_CYCLES));
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Wishbone master
  //////////////////////////////////////////////////////////////////////

  // Request held until ack, ack seen at the falling edge
  task automatic bus_write(input logic [5:0] idx, input logic [31:0] data);
    @(posedge clk);
    wb_cyc <= 1'b1;
    wb_stb <= 1'b1;
    wb_we  <= 1'b1;
    wb_adr <= {idx, 2'b00};
    wb_dat <= data;
    wb_sel <= 4'hf;
    @(negedge clk);
    while (!wb_ack) @(negedge clk);
    @(posedge clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  task automatic bus_read(input logic [5:0] idx, output logic [31:0] data);
    @(posedge clk);
    wb_cyc <= 1'b1;
    wb_stb <= 1'b1;
    wb_we  <= 1'b0;
    wb_adr <= {idx, 2'b00};
    @(negedge clk);
    while (!wb_ack) @(negedge clk);
    data = wb_rdat;
    @(posedge clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Reference model and table
  //////////////////////////////////////////////////////////////////////

  // RV32M result by funct3
  function automatic logic [31:0] expected_md(input logic [2:0] f3, input logic [31:0] a,
                                              input logic [31:0] b);
    logic [63:0] sa;
    logic [63:0] sb;
    logic [63:0] ua;
    logic [63:0] ub;
    logic [63:0] p;
    logic        ovf;
    logic [31:0] sq;
    logic [31:0] sr;
    sa  = {{32{a[31]}}, a};
    sb  = {{32{b[31]}}, b};
    ua  = {32'b0, a};
    ub  = {32'b0, b};
    ovf = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
    // Signed quotient and remainder where defined
    if ((b != 0) && !ovf) begin
      sq = $signed(a) / $signed(b);
      sr = $signed(a) % $signed(b);
    end else begin
      sq = '0;
      sr = '0;
    end
    case (f3)
      3'd0: p = ua * ub;
      3'd1: p = sa * sb;
      3'd2: p = sa * ub;
      3'd3: p = ua * ub;
      default: p = '0;
    endcase
    case (f3)
      3'd0: return p[31:0];
      3'd1, 3'd2, 3'd3: return p[63:32];
      // Zero divisor gives all ones, overflow gives the dividend
      3'd4: return (b == 0) ? 32'hffff_ffff : (ovf ? a : sq);
      3'd5: return (b == 0) ? 32'hffff_ffff : a / b;
      // Zero divisor keeps the dividend, overflow leaves nothing
      3'd6: return (b == 0) ? a : (ovf ? 32'h0 : sr);
      default: return (b == 0) ? a : a % b;
    endcase
  endfunction

  // rd preload, lets an untouched rd be seen
  function automatic logic [31:0] sentinel(input int idx);
    return 32'h5a00_0000 | idx;
  endfunction

  // Register fill, spreads the full index
  function automatic logic [31:0] fill_value(input int idx);
    return 32'h9e37_79b9 * (idx + 1);
  endfunction

  task automatic add_row(input logic [6:0] f7, input logic [6:0] opc, input logic [2:0] f3,
                         input logic [4:0] rs1, input logic [4:0] rs2, input logic [4:0] rd,
                         input logic [31:0] a, input logic [31:0] b);
    row_t r;
    r.legal = (opc == m_unit_pkg::OPCODE_OP) && (f7 == m_unit_pkg::FUNCT7_MULDIV);
    r.instr = {f7, rs2, rs1, f3, rd, opc};
    r.a     = a;
    r.b     = b;
    if (rd == 5'd0) begin
      r.expected = '0;
    end else if (r.legal) begin
      r.expected = expected_md(f3, a, b);
    end else begin
      r.expected = sentinel(rows.size());
    end
    rows.push_back(r);
  endtask

  // Preload rd, load operands, issue, then read rd, status and instruction back
  task automatic run_row(input int idx);
    row_t        r;
    logic [31:0] got;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    r   = rows[idx];
    rs1 = r.instr[19:15];
    rs2 = r.instr[24:20];
    rd  = r.instr[11:7];
    bus_write({1'b0, rd}, sentinel(idx));
    bus_write({1'b0, rs1}, r.a);
    bus_write({1'b0, rs2}, r.b);
    bus_write(m_unit_pkg::WB_ADR_INSTR, r.instr);
    bus_read({1'b0, rd}, got);
    expect_word($sformatf("row %0d rd x%0d", idx, rd), got, r.expected);
    bus_read(m_unit_pkg::WB_ADR_STATUS, got);
    expect_word($sformatf("row %0d status", idx), got, {31'b0, ~r.legal});
    bus_read(m_unit_pkg::WB_ADR_INSTR, got);
    expect_word($sformatf("row %0d instruction readback", idx), got, r.instr);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] got;
    logic [31:0] a;
    logic [31:0] b;
    logic [2:0]  f3;
    seed   = 32'h4ebf10fe;
    arst_n = 1'b0;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    wb_adr = '0;
    wb_dat = '0;
    wb_sel = '0;

    // Signed and unsigned corners on every operator
    for (int op = 0; op < 8; op++) begin
      add_row(7'h01, 7'h33, op, 5'd3, 5'd4, 8 + op, 32'h8000_0000, 32'hffff_ffff);
      add_row(7'h01, 7'h33, op, 5'd3, 5'd4, 8 + op, 32'hffff_ffff, 32'h7fff_ffff);
      add_row(7'h01, 7'h33, op, 5'd3, 5'd4, 8 + op, 32'h1234_5678, 32'h9abc_def0);
    end
    // Zero divisor
    for (int op = 4; op < 8; op++) begin
      add_row(7'h01, 7'h33, op, 5'd3, 5'd4, 16 + op, 32'hffff_fff9, 32'h0);
    end
    // rs1 reused as rd, then x0 as rd
    add_row(7'h01, 7'h33, 3'd1, 5'd9, 5'd10, 5'd9, 32'h8765_4321, 32'h0fed_cba9);
    add_row(7'h01, 7'h33, 3'd0, 5'd3, 5'd4, 5'd0, 32'h0000_0007, 32'h0000_0009);
    // Wrong funct7, wrong opcode, plain add
    add_row(7'h02, 7'h33, 3'd0, 5'd3, 5'd4, 5'd20, 32'h11, 32'h22);
    add_row(7'h01, 7'h3b, 3'd4, 5'd3, 5'd4, 5'd21, 32'h33, 32'h44);
    add_row(7'h00, 7'h33, 3'd0, 5'd3, 5'd4, 5'd22, 32'h55, 32'h66);
    // Random rows, some with short divisors
    for (int i = 0; i < NUM_RAND; i++) begin
      f3 = $random(seed);
      a  = $random(seed);
      b  = $random(seed);
      if (i % 4 == 3) begin
        b = b >> 24;
      end
      add_row(7'h01, 7'h33, f3, 5'd5, 5'd6, 7 + i % 24, a, b);
    end

    repeat (16) @(posedge clk);
    arst_n <= 1'b1;

    // Everything zero out of reset
    for (int i = 0; i < m_unit_pkg::NUM_REGS; i++) begin
      bus_read(i, got);
      expect_word($sformatf("reset value x%0d", i), got, 32'h0);
    end
    bus_read(m_unit_pkg::WB_ADR_STATUS, got);
    expect_word("reset status", got, 32'h0);

    // Register write and readback, x0 stays zero
    for (int i = 0; i < m_unit_pkg::NUM_REGS; i++) begin
      bus_write(i, fill_value(i));
    end
    for (int i = 0; i < m_unit_pkg::NUM_REGS; i++) begin
      bus_read(i, got);
      expect_word($sformatf("readback x%0d", i), got, (i == 0) ? 32'h0 : fill_value(i));
    end

    for (int i = 0; i < rows.size(); i++) begin
      run_row(i);
    end

    $display("Test completed successfully");
    $finish;
  end

endmodule

//--- m_unit.f
common/m_unit_pkg.sv
common/m_op_if.sv
src/m_decoder.sv
src/m_regfile.sv
mul_div/m_multiplier.sv
mul_div/m_divider.sv
src/m_wb_ctrl.sv
src/m_unit_top.sv
testbench/m_unit_tb.sv
